/* filelist.f */
+incdir+rtl
rtl/hdmi_bus_pkg.sv
rtl/hdmi_video_pkg.sv
rtl/ahb_draw_regs.sv
rtl/draw_ctrl.sv
rtl/frame_buffer.sv
rtl/video_timing.sv
rtl/pixel_scanout.sv
rtl/hdmi_draw_top.sv
tests/tb_hdmi_draw.sv

/* Bender.yml */
package:
  name: hdmi_draw

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/hdmi_bus_pkg.sv
      - rtl/hdmi_video_pkg.sv
      - rtl/ahb_draw_regs.sv
      - rtl/draw_ctrl.sv
      - rtl/frame_buffer.sv
      - rtl/video_timing.sv
      - rtl/pixel_scanout.sv
      - rtl/hdmi_draw_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_hdmi_draw.sv

/* tests/tb_hdmi_draw.sv */
`include "hdmi_defines.svh"

module tb_hdmi_draw
    import hdmi_video_pkg::*;
();

    localparam int FB         = `FB_DEPTH;
    localparam int LINE_CYC   = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;
    localparam int FRAME_CYC  = LINE_CYC * (`V_ACTIVE + `V_FP + `V_SYNC + `V_BP);
    localparam int VS_CYC     = LINE_CYC * `V_SYNC;
    localparam int HS_CYC     = `H_SYNC * (`V_ACTIVE + `V_FP + `V_SYNC + `V_BP);
    localparam int WAIT_LIMIT = 2 * FRAME_CYC;
    localparam int IDLE_POLLS = 200;

    logic        HCLK;
    logic        HRESETn;
    logic        HSEL;
    logic [31:0] HADDR;
    logic [1:0]  HTRANS;
    logic        HWRITE;
    logic [31:0] HWDATA;
    logic        HREADY;
    logic        HREADYOUT;
    logic [31:0] HRDATA;
    logic        HRESP;
    logic        hsync;
    logic        vsync;
    logic        de;
    rgb_t        rgb;

    logic [23:0] exp_fb [FB];                // Expected picture
    logic [23:0] cap [FB];                   // Last captured frame
    integer      seed;
    int          cycle;
    int          mismatches;
    int          timeouts;

    hdmi_draw_top dut_i (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .HSEL      (HSEL),
        .HADDR     (HADDR),
        .HTRANS    (HTRANS),
        .HWRITE    (HWRITE),
        .HWDATA    (HWDATA),
        .HREADY    (HREADY),
        .HREADYOUT (HREADYOUT),
        .HRDATA    (HRDATA),
        .HRESP     (HRESP),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de),
        .rgb       (rgb)
    );

    always #4 HCLK = ~HCLK;

    always @(posedge HCLK)
        cycle <= cycle + 1;                  // Read only at falling edges

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
        mismatches++;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        timeouts++;
    endtask

    function automatic logic [23:0] next_color();
        logic [31:0] r;
        r = $random(seed);
        return r[23:0];
    endfunction

    task automatic ahb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge HCLK);
        HSEL   <= 1'b1;
        HTRANS <= 2'b10;                     // NONSEQ
        HWRITE <= 1'b1;
        HADDR  <= {24'h0, addr};
        @(posedge HCLK);
        HSEL   <= 1'b0;
        HTRANS <= 2'b00;
        HWRITE <= 1'b0;
        HWDATA <= data;                      // Data phase
    endtask

    task automatic ahb_read(input logic [7:0] addr, output logic [31:0] data, output int stamp);
        @(posedge HCLK);
        HSEL   <= 1'b1;
        HTRANS <= 2'b10;
        HWRITE <= 1'b0;
        HADDR  <= {24'h0, addr};
        @(posedge HCLK);
        HSEL   <= 1'b0;
        HTRANS <= 2'b00;
        @(negedge HCLK);
        data  = HRDATA;
        stamp = cycle;
        if (HREADYOUT !== 1'b1)
            report_mismatch("HREADYOUT", 32'h1, HREADYOUT);
        if (HRESP !== 1'b0)
            report_mismatch("HRESP", 32'h0, HRESP);
    endtask

    task automatic draw(input logic [15:0] x, input logic [15:0] y,
                        input logic [23:0] color, input logic [23:0] len);
        ahb_write(`REG_X, {16'h0, x});
        ahb_write(`REG_Y, {16'h0, y});
        ahb_write(`REG_COLOR, {8'h0, color});
        ahb_write(`REG_LEN, {8'h0, len});
        ahb_write(`REG_CTRL, 32'h1);
    endtask

    // Row-major run that wraps past the last pixel
    task automatic paint_model(input int x, input int y, input int len, input logic [23:0] color);
        int i;
        for (i = 0; i < len; i++)
            exp_fb[(y * `H_ACTIVE + x + i) % FB] = color;
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        int          stamp;
        int          polls;
        polls  = 0;
        status = 32'h1;
        while (status[0] !== 1'b0 && polls < IDLE_POLLS)
        begin
            ahb_read(`REG_STATUS, status, stamp);
            polls++;
        end
        if (status[0] !== 1'b0)
            report_timeout("draw engine still busy after polling REG_STATUS");
    endtask

    task automatic capture_frame();
        int waited;
        int width;
        int rest;
        int n;
        int hs_high;
        waited = 0;
        @(negedge HCLK);
        while (vsync !== 1'b0 && waited < WAIT_LIMIT)
        begin
            @(negedge HCLK);
            waited++;
        end
        if (vsync !== 1'b0)
        begin
            report_timeout("vsync never went low");
            return;
        end
        waited = 0;
        while (vsync !== 1'b1 && waited < WAIT_LIMIT)
        begin
            @(negedge HCLK);
            waited++;
        end
        if (vsync !== 1'b1)
        begin
            report_timeout("no vsync pulse within two frames");
            return;
        end
        width   = 0;
        hs_high = 0;
        while (vsync === 1'b1 && width < WAIT_LIMIT)
        begin
            if (hsync === 1'b1)
                hs_high++;
            @(negedge HCLK);
            width++;
        end
        if (vsync !== 1'b0)
        begin
            report_timeout("vsync pulse never ended");
            return;
        end
        rest = 0;
        n    = 0;
        while (vsync !== 1'b1 && rest < WAIT_LIMIT)  // Up to the next frame's pulse
        begin
            if (hsync === 1'b1)
                hs_high++;
            if (de === 1'b1)
            begin
                if (n < FB)
                    cap[n] = rgb;
                n++;
            end
            else if (rgb !== '0)
                report_mismatch("rgb outside de", 32'h0, {8'h0, rgb});
            @(negedge HCLK);
            rest++;
        end
        if (vsync !== 1'b1)
        begin
            report_timeout("second vsync pulse never came");
            return;
        end
        if (width != VS_CYC)
            report_mismatch("vsync pulse width", VS_CYC, width);
        if (width + rest != FRAME_CYC)
            report_mismatch("vsync period", FRAME_CYC, width + rest);
        if (hs_high != HS_CYC)
            report_mismatch("hsync high cycles per frame", HS_CYC, hs_high);
        if (n != FB)
            report_mismatch("de samples per frame", FB, n);
    endtask

    task automatic compare_frame(input string label);
        int i;
        for (i = 0; i < FB; i++)
            if (cap[i] !== exp_fb[i])
                report_mismatch($sformatf("rgb %s pixel %0d", label, i), exp_fb[i], cap[i]);
    endtask

    task automatic check_reset_readback();
        logic [31:0] data;
        int          stamp;
        @(negedge HCLK);
        if (de !== 1'b0)
            report_mismatch("de", 32'h0, de);
        if (hsync !== 1'b0)
            report_mismatch("hsync", 32'h0, hsync);
        if (vsync !== 1'b0)
            report_mismatch("vsync", 32'h0, vsync);
        if (HRDATA !== 32'h0)
            report_mismatch("HRDATA", 32'h0, HRDATA);
        ahb_read(`REG_ID, data, stamp);
        if (data !== 32'h55)
            report_mismatch("HRDATA (REG_ID)", 32'h55, data);
        ahb_read(`REG_STATUS, data, stamp);
        if (data !== 32'h0)
            report_mismatch("HRDATA (REG_STATUS)", 32'h0, data);
        ahb_read(8'h14, data, stamp);
        if (data !== 32'h0)
            report_mismatch("HRDATA (offset 0x14)", 32'h0, data);
    endtask

    task automatic fill_whole_frame();
        logic [23:0] color;
        color = next_color();
        draw(0, 0, color, FB);
        wait_idle();
        paint_model(0, 0, FB, color);
        capture_frame();
        compare_frame("fill");
    endtask

    task automatic draw_wrapping_run();
        logic [23:0] color;
        color = next_color();
        draw(14, 2, color, 5);               // Pixels 46 to 50
        wait_idle();
        paint_model(14, 2, 5, color);
        capture_frame();
        compare_frame("wrap");
    endtask

    task automatic run_while_busy();
        logic [23:0] first_color;
        logic [23:0] second_color;
        logic [31:0] status;
        logic        exp_busy;
        int          t0;
        int          stamp;
        int          d;
        int          polls;
        first_color  = next_color();
        second_color = next_color();
        if (second_color == first_color)
            second_color = ~first_color;
        draw(3, 4, first_color, 20);
        @(negedge HCLK);
        t0 = cycle;                          // Data phase of the REG_CTRL write
        ahb_read(`REG_STATUS, status, stamp);
        if (status !== 32'h1)
            report_mismatch("HRDATA (REG_STATUS right after start)", 32'h1, status);
        ahb_write(`REG_COLOR, {8'h0, second_color});
        ahb_write(`REG_CTRL, 32'h1);         // Should be dropped
        polls = 0;
        while (status[0] === 1'b1 && polls < IDLE_POLLS)
        begin
            ahb_read(`REG_STATUS, status, stamp);
            d        = stamp - t0;
            exp_busy = (d >= 1) && (d <= 20);
            if (status !== {31'h0, exp_busy})
                report_mismatch($sformatf("HRDATA (REG_STATUS %0d cycles after start)", d),
                                {31'h0, exp_busy}, status);
            polls++;
        end
        if (status[0] !== 1'b0)
            report_timeout("busy never cleared after a run of 20");
        paint_model(3, 4, 20, first_color);
        capture_frame();
        compare_frame("busy run");
    endtask

    task automatic start_zero_length();
        logic [31:0] status;
        int          stamp;
        draw(5, 1, next_color(), 0);
        ahb_read(`REG_STATUS, status, stamp);
        if (status !== 32'h0)
            report_mismatch("HRDATA (REG_STATUS after zero length)", 32'h0, status);
        capture_frame();
        compare_frame("zero length");
    endtask

    initial
    begin
        HCLK       = 1'b0;
        HRESETn    = 1'b0;
        HSEL       = 1'b0;
        HADDR      = 32'h0;
        HTRANS     = 2'b00;
        HWRITE     = 1'b0;
        HWDATA     = 32'h0;
        HREADY     = 1'b1;
        seed       = 32'h77b8_0319;
        cycle      = 0;
        mismatches = 0;
        timeouts   = 0;

        repeat (4) @(posedge HCLK);
        HRESETn <= 1'b1;

        check_reset_readback();
        fill_whole_frame();
        draw_wrapping_run();
        run_while_busy();
        start_zero_length();

        $display("Summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

/* rtl/hdmi_draw_top.sv */
`include "hdmi_defines.svh"

module hdmi_draw_top
    import hdmi_video_pkg::*;
(
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic        HSEL,
    input  logic [31:0] HADDR,
    input  logic [1:0]  HTRANS,
    input  logic        HWRITE,
    input  logic [31:0] HWDATA,
    input  logic        HREADY,
    output logic        HREADYOUT,
    output logic [31:0] HRDATA,
    output logic        HRESP,
    output logic        hsync,
    output logic        vsync,
    output logic        de,
    output rgb_t        rgb
);

    draw_cmd_t         cmd;
    logic              start;
    logic              busy;
    fb_wr_t            fb_wr;
    vid_ctl_t          vid;
    logic [`FB_AW-1:0] rd_addr;
    rgb_t              rd_data;

    ahb_draw_regs regs_i (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .HSEL      (HSEL),
        .HADDR     (HADDR),
        .HTRANS    (HTRANS),
        .HWRITE    (HWRITE),
        .HWDATA    (HWDATA),
        .HREADY    (HREADY),
        .HREADYOUT (HREADYOUT),
        .HRDATA    (HRDATA),
        .HRESP     (HRESP),
        .cmd       (cmd),
        .start     (start),
        .busy      (busy)
    );

    draw_ctrl ctrl_i (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .cmd     (cmd),
        .start   (start),
        .busy    (busy),
        .fb_wr   (fb_wr)
    );

    frame_buffer fb_i (
        .HCLK    (HCLK),
        .fb_wr   (fb_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    video_timing timing_i (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .vid     (vid)
    );

    pixel_scanout scan_i (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .vid     (vid),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .rgb     (rgb)
    );

endmodule

/* rtl/pixel_scanout.sv */
`include "hdmi_defines.svh"

module pixel_scanout
    import hdmi_video_pkg::*;
(
    input  logic              HCLK,
    input  logic              HRESETn,
    input  vid_ctl_t          vid,
    output logic [`FB_AW-1:0] rd_addr,
    input  rgb_t              rd_data,
    output logic              hsync,
    output logic              vsync,
    output logic              de,
    output rgb_t              rgb
);

    logic [31:0] lin_addr;
    vid_ctl_t    vid_q;

    // Row-major, only meaningful inside the active area
    assign lin_addr = 32'(vid.v) * `H_ACTIVE + 32'(vid.h);
    assign rd_addr  = lin_addr[`FB_AW-1:0];

    // Matches the one-cycle memory read
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
            vid_q <= '0;
        else
            vid_q <= vid;
    end

    assign hsync = vid_q.hsync;
    assign vsync = vid_q.vsync;
    assign de    = vid_q.de;
    assign rgb   = vid_q.de ? rd_data : '0;     // Black in blanking

endmodule

/* rtl/video_timing.sv */
`include "hdmi_defines.svh"

module video_timing
    import hdmi_video_pkg::*;
(
    input  logic     HCLK,
    input  logic     HRESETn,
    output vid_ctl_t vid
);

    localparam int HS_START = `H_ACTIVE + `H_FP;
    localparam int HS_END   = HS_START + `H_SYNC;
    localparam int VS_START = `V_ACTIVE + `V_FP;
    localparam int VS_END   = VS_START + `V_SYNC;

    logic [H_CW-1:0] h_cnt;
    logic [V_CW-1:0] v_cnt;

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (h_cnt == H_CW'(H_TOTAL - 1))
        begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_CW'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
        end
        else
            h_cnt <= h_cnt + 1'b1;
    end

    always_comb
    begin
        vid.h     = h_cnt;
        vid.v     = v_cnt;
        vid.de    = (int'(h_cnt) < `H_ACTIVE) && (int'(v_cnt) < `V_ACTIVE);
        vid.hsync = (int'(h_cnt) >= HS_START) && (int'(h_cnt) < HS_END);
        vid.vsync = (int'(v_cnt) >= VS_START) && (int'(v_cnt) < VS_END);
    end

    a_cnt_range: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (int'(h_cnt) < H_TOTAL) && (int'(v_cnt) < V_TOTAL));

endmodule

/* rtl/frame_buffer.sv */
`include "hdmi_defines.svh"

module frame_buffer
    import hdmi_video_pkg::*;
(
    input  logic              HCLK,
    input  fb_wr_t            fb_wr,
    input  logic [`FB_AW-1:0] rd_addr,
    output rgb_t              rd_data
);

    rgb_t mem [`FB_DEPTH];

    always_ff @(posedge HCLK)
    begin
        if (fb_wr.en)
            mem[fb_wr.addr] <= fb_wr.data;
    end

    // Read before write on a collision
    always_ff @(posedge HCLK)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* rtl/draw_ctrl.sv */
`include "hdmi_defines.svh"

module draw_ctrl
    import hdmi_video_pkg::*;
(
    input  logic      HCLK,
    input  logic      HRESETn,
    input  draw_cmd_t cmd,
    input  logic      start,
    output logic      busy,
    output fb_wr_t    fb_wr
);

    localparam int AW = `FB_AW;

    typedef enum logic {IDLE, RUN} state_t;

    state_t      state;
    logic [23:0] remain;
    logic        go;
    logic [31:0] base_addr;
    logic [AW-1:0] addr_q;
    rgb_t        color_q;

    // Start pixel, wrapped into the buffer
    assign base_addr = (32'(cmd.y) * `H_ACTIVE + 32'(cmd.x)) % `FB_DEPTH;
    assign go        = (state == IDLE) && start && (cmd.len != '0);

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            state  <= IDLE;
            remain <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (go)
                    begin
                        state  <= RUN;
                        remain <= cmd.len;
                    end
                end
                RUN:
                begin
                    remain <= remain - 1'b1;
                    if (remain == 24'd1)
                        state <= IDLE;      // Last pixel this cycle
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge HCLK)
    begin
        if (go)
        begin
            addr_q  <= base_addr[AW-1:0];
            color_q <= cmd.color;
        end
        else if (state == RUN)
            addr_q <= (addr_q == AW'(`FB_DEPTH - 1)) ? '0 : addr_q + 1'b1;
    end

    assign busy       = (state == RUN);
    assign fb_wr.en   = (remain != '0);     // Pixels still owed
    assign fb_wr.addr = addr_q;
    assign fb_wr.data = color_q;

    a_wr_busy: assert property (@(posedge HCLK) disable iff (!HRESETn)
        fb_wr.en |-> busy);

endmodule

/* rtl/ahb_draw_regs.sv */
`include "hdmi_defines.svh"

module ahb_draw_regs
    import hdmi_bus_pkg::*;
    import hdmi_video_pkg::*;
(
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic        HSEL,
    input  logic [31:0] HADDR,
    input  logic [1:0]  HTRANS,
    input  logic        HWRITE,
    input  logic [31:0] HWDATA,
    input  logic        HREADY,
    output logic        HREADYOUT,
    output logic [31:0] HRDATA,
    output logic        HRESP,
    output draw_cmd_t   cmd,
    output logic        start,
    input  logic        busy
);

    logic        accept;
    logic        req_vld_q;
    ahb_req_t    req_q;
    logic        wr_phase;
    logic        rd_phase;
    reg_status_t status;

    assign HREADYOUT = 1'b1;
    assign HRESP     = 1'b0;                 // Always OKAY

    assign accept = HSEL && HTRANS[1] && HREADY;

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            req_vld_q <= 1'b0;
            req_q     <= '0;
        end
        else
        begin
            req_vld_q <= accept;
            if (accept)
            begin
                req_q.write <= HWRITE;
                req_q.addr  <= HADDR[7:0];
            end
        end
    end

    assign wr_phase = req_vld_q && req_q.write && HREADY;
    assign rd_phase = req_vld_q && !req_q.write;

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
            cmd <= '0;
        else if (wr_phase)
        begin
            case (req_q.addr)
                `REG_X:     cmd.x     <= HWDATA[15:0];
                `REG_Y:     cmd.y     <= HWDATA[15:0];
                `REG_COLOR: cmd.color <= HWDATA[23:0];   // R in 23:16
                `REG_LEN:   cmd.len   <= HWDATA[23:0];
                default:    ;
            endcase
        end
    end

    // Draw_ctrl decides whether the start is taken
    assign start = wr_phase && (req_q.addr == `REG_CTRL) && HWDATA[0];

    assign status.rsvd = '0;
    assign status.busy = busy;

    always_comb
    begin
        HRDATA = '0;
        if (rd_phase)
        begin
            case (req_q.addr)
                `REG_ID:     HRDATA = `ID_VALUE;
                `REG_STATUS: HRDATA = status;
                default:     HRDATA = '0;
            endcase
        end
    end

    a_start_single: assert property (@(posedge HCLK) disable iff (!HRESETn)
        start |=> !start);

endmodule

/* rtl/hdmi_video_pkg.sv */
`include "hdmi_defines.svh"

package hdmi_video_pkg;

    localparam int H_TOTAL = `H_ACTIVE + `H_FP + `H_SYNC + `H_BP;
    localparam int V_TOTAL = `V_ACTIVE + `V_FP + `V_SYNC + `V_BP;
    localparam int H_CW    = $clog2(H_TOTAL);
    localparam int V_CW    = $clog2(V_TOTAL);

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        rgb_t        color;
        logic [23:0] len;
    } draw_cmd_t;

    typedef struct packed {
        logic              en;
        logic [`FB_AW-1:0] addr;
        rgb_t              data;
    } fb_wr_t;

    // Raw counter values, valid as coordinates while de is high
    typedef struct packed {
        logic            hsync;
        logic            vsync;
        logic            de;
        logic [H_CW-1:0] h;
        logic [V_CW-1:0] v;
    } vid_ctl_t;

endpackage

/* rtl/hdmi_bus_pkg.sv */
package hdmi_bus_pkg;

    // Address phase as seen by the register block
    typedef struct packed {
        logic       write;
        logic [7:0] addr;
    } ahb_req_t;

    // Layout of the status word on reads
    typedef struct packed {
        logic [30:0] rsvd;
        logic        busy;
    } reg_status_t;

endpackage

/* rtl/hdmi_defines.svh */
`ifndef HDMI_DEFINES_SVH
`define HDMI_DEFINES_SVH

// Horizontal timing in pixels
`define H_ACTIVE 16
`define H_FP     2
`define H_SYNC   3
`define H_BP     3

// Vertical timing in lines
`define V_ACTIVE 8
`define V_FP     1
`define V_SYNC   2
`define V_BP     1

// One word per active pixel
`define FB_DEPTH 128
`define FB_AW    7

`define REG_X      8'h00
`define REG_Y      8'h04
`define REG_COLOR  8'h08
`define REG_LEN    8'h0C
`define REG_CTRL   8'h10
`define REG_ID     8'h18
`define REG_STATUS 8'h1C

`define ID_VALUE 32'h0000_0055

`endif
